// ==== axis_pipe_consts.svh ====
// shared constants for the byte-wide axi4-stream frame pipeline
// stream width, frame length limit and status field widths

`ifndef AXIS_PIPE_CONSTS_SVH
`define AXIS_PIPE_CONSTS_SVH

// tdata width in bits, one byte per beat
`define AXIS_DATA_WIDTH 8

// longest legal frame in beats
// anything longer is flagged oversize
`define AXIS_MAX_FRAME_LEN 64

// beat count field, saturates at all ones
`define FRAME_LEN_WIDTH 16

// modular byte sum field
`define FRAME_SUM_WIDTH 16

`endif

// ==== axis_pipe_pkg.sv ====
// types shared by the frame pipeline
// one stream beat and the per-frame status record

`include "axis_pipe_consts.svh"

package axis_pipe_pkg;

    // one stream beat, travels with separate valid/ready
    typedef struct packed {
        logic [`AXIS_DATA_WIDTH-1:0] tdata;
        // end of frame
        logic                        tlast;
        // marks a bad beat
        logic                        tuser;
    } axis_beat_t;

    // totals for one frame, reported on the status strobe
    typedef struct packed {
        // beat count
        logic [`FRAME_LEN_WIDTH-1:0] len;
        // byte sum modulo 2**FRAME_SUM_WIDTH
        logic [`FRAME_SUM_WIDTH-1:0] sum;
        // some beat had tuser set
        logic                        err;
        // len went past the maximum
        logic                        oversize;
    } frame_stat_t;

endpackage

// ==== axis_register.sv ====
// axi4-stream register slice with a skid buffer
// full throughput with a registered ready toward the source

`timescale 1ns/1ps

module axis_register import axis_pipe_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    // upstream side
    input  axis_beat_t s_beat,
    input  logic       s_valid,
    output logic       s_ready,

    // downstream side
    output axis_beat_t m_beat,
    output logic       m_valid,
    input  logic       m_ready
);

    // registered ready seen by the source
    logic       s_ready_reg;

    // output register, drives the downstream side
    axis_beat_t out_beat;
    logic       out_valid;

    // skid register, catches the beat in flight when downstream stalls
    axis_beat_t skid_beat;
    logic       skid_valid;

    // output register may load when it is empty or being drained
    logic       out_load;

    assign out_load = m_ready || !out_valid;

    assign s_ready = s_ready_reg;
    assign m_beat  = out_beat;
    assign m_valid = out_valid;

    // control state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s_ready_reg <= 1'b0;
            out_valid   <= 1'b0;
            skid_valid  <= 1'b0;
        end else begin
            // ready next cycle if downstream takes data, or if the skid
            // stays empty even when a beat lands this cycle
            s_ready_reg <= m_ready || (!skid_valid && (!out_valid || !s_valid));

            if (s_ready_reg) begin
                if (out_load) begin
                    out_valid <= s_valid;
                end else begin
                    // output stalled, park the incoming beat
                    skid_valid <= s_valid;
                end
            end else if (m_ready) begin
                // source is held off, drain skid into output
                out_valid  <= skid_valid;
                skid_valid <= 1'b0;
            end
        end
    end

    // payload follows the same steering as the valid bits
    always_ff @(posedge clk) begin
        if (s_ready_reg) begin
            if (out_load) begin
                out_beat <= s_beat;
            end else begin
                skid_beat <= s_beat;
            end
        end else if (m_ready) begin
            out_beat <= skid_beat;
        end
    end

    // a stalled beat must be held unchanged until it is taken
    a_hold_stalled: assert property (@(posedge clk) disable iff (rst)
        m_valid && !m_ready |=> m_valid && $stable(m_beat));

    // registered ready must never let a beat land on a full skid
    a_skid_no_overwrite: assert property (@(posedge clk) disable iff (rst)
        s_ready_reg && s_valid && out_valid && !m_ready |-> !skid_valid);

endmodule

// ==== axis_frame_monitor.sv ====
// passive frame monitor on one stream handshake point
// counts beats, sums bytes, flags tuser and oversize, strobes status per frame

`timescale 1ns/1ps

`include "axis_pipe_consts.svh"

module axis_frame_monitor import axis_pipe_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    // observed stream, never driven from here
    input  axis_beat_t  beat,
    input  logic        valid,
    input  logic        ready,

    // one status record per frame
    output frame_stat_t stat,
    output logic        stat_valid
);

    // running state for the current frame
    logic [`FRAME_LEN_WIDTH-1:0] run_len;
    logic [`FRAME_SUM_WIDTH-1:0] run_sum;
    logic                        run_err;
    logic                        run_ovs;

    // values after the beat on the bus is counted
    logic [`FRAME_LEN_WIDTH-1:0] next_len;
    logic [`FRAME_SUM_WIDTH-1:0] next_sum;
    logic                        next_err;
    logic                        next_ovs;

    logic                        xfer;

    assign xfer = valid && ready;

    always_comb begin
        // count saturates, so a runaway frame still reads as oversize
        if (run_len == '1) begin
            next_len = run_len;
        end else begin
            next_len = run_len + 1'b1;
        end
        // byte is zero extended, sum wraps naturally
        next_sum = run_sum + `FRAME_SUM_WIDTH'(beat.tdata);
        next_err = run_err || beat.tuser;
        next_ovs = run_ovs || (next_len > `FRAME_LEN_WIDTH'(`AXIS_MAX_FRAME_LEN));
    end

    // running counters and the strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run_len    <= '0;
            run_sum    <= '0;
            run_err    <= 1'b0;
            run_ovs    <= 1'b0;
            stat_valid <= 1'b0;
        end else begin
            stat_valid <= xfer && beat.tlast;
            if (xfer) begin
                if (beat.tlast) begin
                    // frame done, start clean for the next one
                    run_len <= '0;
                    run_sum <= '0;
                    run_err <= 1'b0;
                    run_ovs <= 1'b0;
                end else begin
                    run_len <= next_len;
                    run_sum <= next_sum;
                    run_err <= next_err;
                    run_ovs <= next_ovs;
                end
            end
        end
    end

    // status record, qualified by stat_valid
    always_ff @(posedge clk) begin
        if (xfer && beat.tlast) begin
            stat.len      <= next_len;
            stat.sum      <= next_sum;
            stat.err      <= next_err;
            stat.oversize <= next_ovs;
        end
    end

    // back to back strobes only when the later frame was a single beat
    a_strobe_spacing: assert property (@(posedge clk) disable iff (rst)
        stat_valid |=> !stat_valid || stat.len == `FRAME_LEN_WIDTH'(1));

endmodule

// ==== axis_frame_pipe.sv ====
// frame pipeline top level
// input slice, passive frame monitor on the middle stream, output slice

`timescale 1ns/1ps

module axis_frame_pipe import axis_pipe_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    // stream in
    input  axis_beat_t  s_beat,
    input  logic        s_valid,
    output logic        s_ready,

    // stream out
    output axis_beat_t  m_beat,
    output logic        m_valid,
    input  logic        m_ready,

    // per-frame status strobe
    output frame_stat_t stat,
    output logic        stat_valid
);

    // stream between the two slices, tapped by the monitor
    axis_beat_t mid_beat;
    logic       mid_valid;
    logic       mid_ready;

    axis_register u_in (
        .clk     (clk),
        .rst     (rst),
        .s_beat  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_beat  (mid_beat),
        .m_valid (mid_valid),
        .m_ready (mid_ready)
    );

    // observes only, ready comes from the output slice
    axis_frame_monitor u_mon (
        .clk        (clk),
        .rst        (rst),
        .beat       (mid_beat),
        .valid      (mid_valid),
        .ready      (mid_ready),
        .stat       (stat),
        .stat_valid (stat_valid)
    );

    axis_register u_out (
        .clk     (clk),
        .rst     (rst),
        .s_beat  (mid_beat),
        .s_valid (mid_valid),
        .s_ready (mid_ready),
        .m_beat  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

endmodule

// ==== tb_axis_frame_pipe.sv ====
// testbench for the axi4-stream frame pipeline
// replays the vector beats in three phases with rising stall rates
// and checks output beats and status strobes

`timescale 1ns/1ps

module tb_axis_frame_pipe import axis_pipe_pkg::*; ();

    localparam int NUM_PHASES = 3;

    logic        clk;
    logic        rst;
    axis_beat_t  s_beat;
    logic        s_valid;
    logic        s_ready;
    axis_beat_t  m_beat;
    logic        m_valid;
    logic        m_ready;
    frame_stat_t stat;
    logic        stat_valid;

    // vectors as read from the file
    axis_beat_t  vec_beats[$];
    frame_stat_t vec_stats[$];

    // still owed by the DUT in the running phase
    axis_beat_t  exp_beats[$];
    frame_stat_t exp_stats[$];
    frame_stat_t exp_stat;

    // phase knobs in percent
    int unsigned stall_pct;
    int unsigned gap_pct;
    bit          check_bubbles;
    bit          out_seen;

    // output beat seen stalled on the previous edge
    bit          held_valid;
    axis_beat_t  held_beat;

    int          checks;
    int          errors;
    int          cycle_count;
    int          cycle_limit;

    axis_frame_pipe dut0 (
        .clk        (clk),
        .rst        (rst),
        .s_beat     (s_beat),
        .s_valid    (s_valid),
        .s_ready    (s_ready),
        .m_beat     (m_beat),
        .m_valid    (m_valid),
        .m_ready    (m_ready),
        .stat       (stat),
        .stat_valid (stat_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("[FAIL] %0t ns %s expected %0h got %0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic expect_true(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            $display("%0t ns: %s", $time, what);
            errors++;
        end
    endtask

    // s_ready, m_valid and stat_valid all held low
    task automatic check_outputs_low();
        compare_value("s_ready", 64'(0), 64'(s_ready));
        compare_value("m_valid", 64'(0), 64'(m_valid));
        compare_value("stat_valid", 64'(0), 64'(stat_valid));
    endtask

    // beat lines hold data last user repeat
    // status lines hold len sum err oversize
    task automatic read_vectors();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  data;
        int          last;
        int          user;
        int          reps;
        int          len;
        logic [15:0] sum;
        int          err;
        int          ovs;
        axis_beat_t  b;
        frame_stat_t s;
        fd = $fopen("axis_frame_pipe_vectors.txt", "r");
        expect_true(fd != 0, "could not open the vectors file");
        if (fd != 0) begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 2 && line.getc(0) == "B") begin
                    n = $sscanf(line.substr(2, line.len() - 1), "%h %d %d %d",
                                data, last, user, reps);
                    expect_true(n == 4, "malformed beat line in the vectors file");
                    b.tdata = data;
                    b.tlast = last[0];
                    b.tuser = user[0];
                    repeat (reps) vec_beats.push_back(b);
                end else if (line.len() > 2 && line.getc(0) == "S") begin
                    n = $sscanf(line.substr(2, line.len() - 1), "%d %h %d %d",
                                len, sum, err, ovs);
                    expect_true(n == 4, "malformed status line in the vectors file");
                    s.len      = len[15:0];
                    s.sum      = sum;
                    s.err      = err[0];
                    s.oversize = ovs[0];
                    vec_stats.push_back(s);
                end
            end
            $fclose(fd);
        end
        expect_true(vec_stats.size() > 0, "the vectors file holds no frames");
    endtask

    // one beat per handshake with random idle cycles between beats when gap_pct is set
    task automatic drive_beats();
        @(posedge clk);
        foreach (vec_beats[i]) begin
            while (gap_pct != 0 && ($urandom % 100) < gap_pct) begin
                s_valid <= 1'b0;
                @(posedge clk);
            end
            s_beat  <= vec_beats[i];
            s_valid <= 1'b1;
            @(posedge clk);
            // s_ready read here is the value the edge used
            while (!s_ready) @(posedge clk);
        end
        s_valid <= 1'b0;
    endtask

    task automatic report_test(input int num, input string name, input int mark);
        $display("test %0d %s: %0d frames, %0d errors", num, name,
                 vec_stats.size(), errors - mark);
    endtask

    // downstream ready stalls at stall_pct percent
    always @(posedge clk) begin
        if (stall_pct == 0) begin
            m_ready <= 1'b1;
        end else begin
            m_ready <= ($urandom % 100) >= stall_pct;
        end
    end

    // output stream and status checks on the values the edge saw
    always @(posedge clk) begin
        if (!rst) begin
            if (held_valid) begin
                compare_value("m_valid while stalled", 64'(1), 64'(m_valid));
                compare_value("m_beat held", 64'(held_beat), 64'(m_beat));
            end
            if (check_bubbles && out_seen && exp_beats.size() > 0) begin
                compare_value("m_valid with continuous input", 64'(1), 64'(m_valid));
            end
            if (m_valid && m_ready) begin
                out_seen = 1'b1;
                if (exp_beats.size() == 0) begin
                    expect_true(1'b0, "output beat arrived when none was expected");
                end else begin
                    compare_value("m_beat", 64'(exp_beats.pop_front()), 64'(m_beat));
                end
            end
            if (stat_valid) begin
                if (exp_stats.size() == 0) begin
                    expect_true(1'b0, "status pulse arrived when no frame was pending");
                end else begin
                    exp_stat = exp_stats.pop_front();
                    compare_value("stat.len", 64'(exp_stat.len), 64'(stat.len));
                    compare_value("stat.sum", 64'(exp_stat.sum), 64'(stat.sum));
                    compare_value("stat.err", 64'(exp_stat.err), 64'(stat.err));
                    compare_value("stat.oversize", 64'(exp_stat.oversize), 64'(stat.oversize));
                end
            end
            held_valid = m_valid && !m_ready;
            held_beat  = m_beat;
        end
    end

    // run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("run timed out after %0d cycles with beats or status outstanding",
                     cycle_count);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        int    p;
        int    mark;
        string phase_name;
        void'($urandom(32'h2b246796));
        rst           = 1'b1;
        s_beat        = '0;
        s_valid       = 1'b0;
        m_ready       = 1'b0;
        stall_pct     = 0;
        gap_pct       = 0;
        check_bubbles = 1'b0;
        out_seen      = 1'b0;
        held_valid    = 1'b0;
        held_beat     = '0;
        checks        = 0;
        errors        = 0;
        cycle_count   = 0;
        cycle_limit   = 0;
        read_vectors();
        cycle_limit = 20 * vec_beats.size() * NUM_PHASES + 200;

        // reset state
        mark = errors;
        repeat (10) begin
            @(negedge clk);
            check_outputs_low();
        end
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_outputs_low();
        @(negedge clk);
        compare_value("s_ready", 64'(1), 64'(s_ready));
        report_test(1, "reset state", mark);

        // same vectors each phase with heavier stalls each time
        for (p = 0; p < NUM_PHASES; p++) begin
            mark = errors;
            case (p)
                0: begin
                    phase_name = "pass-through, no stalls";
                    stall_pct  = 0;
                    gap_pct    = 0;
                end
                1: begin
                    phase_name = "light back-pressure";
                    stall_pct  = 30;
                    gap_pct    = 25;
                end
                default: begin
                    phase_name = "heavy back-pressure";
                    stall_pct  = 70;
                    gap_pct    = 25;
                end
            endcase
            check_bubbles = (p == 0);
            out_seen      = 1'b0;
            exp_beats     = vec_beats;
            exp_stats     = vec_stats;
            drive_beats();
            while (exp_beats.size() > 0 || exp_stats.size() > 0) @(posedge clk);
            // a few quiet cycles to catch extra beats or pulses
            repeat (4) @(posedge clk);
            report_test(p + 2, phase_name, mark);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== axis_frame_pipe_vectors.txt ====
# B data(hex) last user repeat : beat line, repeat copies of the same beat
# S len sum(hex) err oversize  : expected status of the frame just listed
B 5a 1 0 1
S 1 005a 0 0
B 01 0 0 1
B 02 0 0 1
B 03 0 0 1
B 04 1 0 1
S 4 000a 0 0
B ff 1 0 1
S 1 00ff 0 0
B ff 0 0 19
B 80 1 0 1
S 20 136d 0 0
B a5 0 0 1
B 3c 0 0 1
B 00 0 0 1
B 7e 0 0 1
B c3 0 0 1
B 11 0 0 1
B 42 1 0 1
S 7 0275 0 0
# tuser in the middle of a frame
B 10 0 0 1
B 20 0 0 1
B 30 0 1 1
B 40 0 0 1
B 50 1 0 1
S 5 00f0 1 0
# tuser on the last beat
B 09 0 0 1
B 0a 1 1 1
S 2 0013 1 0
B 11 0 0 1
B 22 0 0 1
B 33 1 0 1
S 3 0066 0 0
# oversize frame of 70 beats
B 03 0 0 69
B 07 1 0 1
S 70 00d6 0 1
# exactly the maximum, not oversize
B fe 0 0 63
B fe 1 0 1
S 64 3f80 0 0
# one beat past the maximum
B ff 0 0 64
B ff 1 0 1
S 65 40bf 0 1
B 01 1 0 1
S 1 0001 0 0

// ==== axis_frame_pipe.f ====
+incdir+.
axis_pipe_pkg.sv
axis_register.sv
axis_frame_monitor.sv
axis_frame_pipe.sv
tb_axis_frame_pipe.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
LINT     := --lint-only --timing
TOP      := tb_axis_frame_pipe
FILELIST := axis_frame_pipe.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the log decides pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
